// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - include_dirs:
      - include
    files:
      - hdl/ex_pkg.sv
      - hdl/ex_alu.sv
      - hdl/ex_branch_unit.sv
      - hdl/ex_muldiv.sv
      - hdl/ex_mem_addr.sv
      - hdl/ex_flush_ctrl.sv
      - hdl/ex_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/ex_stage_properties.sv
      - bench/ex_stage_tb.sv

// ==== bench/ex_stage_properties.sv ====
`timescale 1ns/1ps

module ex_stage_properties
    import ex_pkg::*;
(
    input logic      CLK,
    input logic      RST,
    input logic      cache_ready,
    input logic      flush,
    input logic      squash,
    input logic      jump_taken,
    input mem_ctrl_e mem_ctrl
);

    // Ready edges seen since flush rose
    logic [2:0] ready_cnt;
    int         fails = 0;

    always_ff @(posedge CLK)
    begin
        if (RST || !flush)
            ready_cnt <= '0;
        else if (cache_ready)
            ready_cnt <= ready_cnt + 1'b1;
    end

    flush_held: assert property (@(posedge CLK) disable iff (RST)
        flush && ready_cnt < 3 |=> flush)
    else
    begin
        fails++;
        $error("flush dropped before four ready cycles");
    end

    flush_ends: assert property (@(posedge CLK) disable iff (RST)
        flush && cache_ready && ready_cnt == 3 |=> !flush)
    else
    begin
        fails++;
        $error("flush held past four ready cycles");
    end

    // Squash still high in the cycle after flush ends
    squash_covers_flush: assert property (@(posedge CLK) disable iff (RST)
        flush || $fell(flush) |-> squash)
    else
    begin
        fails++;
        $error("squash ended before flush");
    end

    squash_quiet: assert property (@(posedge CLK) disable iff (RST)
        squash |-> !jump_taken && mem_ctrl == MEM_NONE)
    else
    begin
        fails++;
        $error("jump or memory access under squash");
    end

endmodule

bind ex_stage ex_stage_properties props_i (.*);

// ==== bench/ex_stage_tb.sv ====
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_stage_tb
    import ex_pkg::*;
();

    localparam int XLEN  = `EX_XLEN;
    localparam int N_ALU = 120;
    localparam int N_BR  = 48;
    localparam int N_MEM = 42;
    localparam int N_MD  = 24;
    // Muldiv takes about XLEN+2 cycles plus one idle cycle per operation
    localparam int MAX_CYCLES = (N_ALU + N_BR + N_MEM + N_MD * (XLEN + 5) + 80) * 3 / 2;

    logic             CLK;
    logic             RST;
    logic             cache_ready;
    logic             ex_valid;
    alu_op_e          alu_op;
    logic             word_op;
    logic [XLEN-1:0]  src1;
    logic [XLEN-1:0]  src2;
    logic [XLEN-1:0]  cmp1;
    logic [XLEN-1:0]  cmp2;
    logic             branch;
    logic             jump;
    logic             jumpr;
    logic [2:0]       funct3;
    logic [XLEN-1:0]  jump_base;
    logic [XLEN-1:0]  jump_offset;
    logic [XLEN-1:0]  pc_ex;
    logic [XLEN-1:0]  pc_id;
    mem_ctrl_e        mem_ctrl_in;
    ldst_type_e       ldst_type;
    logic [XLEN-1:0]  wb_data;
    logic             jump_taken;
    logic [XLEN-1:0]  jump_addr;
    logic [XLEN-1:0]  data_addr;
    mem_ctrl_e        mem_ctrl;
    logic             load_misaligned;
    logic             store_misaligned;
    logic             inst_misaligned;
    logic             stalled;
    logic             flush;
    logic             squash;
    logic             predicted;

    int               errors;
    int               cycles;
    bit               cmp_en;
    logic [31:0]      seed;

    // Expected values, unpacked from ref_ex
    logic [XLEN-1:0]  e_wb;
    logic             e_jt;
    logic [XLEN-1:0]  e_ja;
    logic [XLEN-1:0]  e_da;
    logic             e_lm;
    logic             e_sm;
    logic             e_im;

    ex_stage ex_stage_i (.*);

    always #5 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles > MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    ////////////////////
    // Helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        seed = xorshift32(seed);
        hi   = seed;
        seed = xorshift32(seed);
        return {hi, seed};
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input bit ok, input string what);
        assert (ok)
        else
        begin
            errors++;
            $display("At %0t ns: %s", $time, what);
        end
    endtask

    task automatic tick();
        @(posedge CLK);
        #1;
    endtask

    ////////////////////
    // Reference model

    function automatic logic [195:0] ref_ex();
        logic [63:0] r;
        logic        cond;
        logic        taken;
        logic [63:0] tgt;
        logic [63:0] addr;
        logic        mis;
        case (alu_op)
            ALU_ADD:   r = src1 + src2;
            ALU_SUB:   r = src1 - src2;
            ALU_SLL:   r = word_op ? src1 << src2[4:0] : src1 << src2[5:0];
            ALU_SRL:   r = word_op ? src1[31:0] >> src2[4:0] : src1 >> src2[5:0];
            ALU_SRA:   r = word_op ? $signed(src1[31:0]) >>> src2[4:0]
                                   : $signed(src1) >>> src2[5:0];
            ALU_XOR:   r = src1 ^ src2;
            ALU_OR:    r = src1 | src2;
            ALU_AND:   r = src1 & src2;
            ALU_SLT:   r = {63'd0, $signed(src1) < $signed(src2)};
            ALU_SLTU:  r = {63'd0, src1 < src2};
            ALU_PASS1: r = src1;
            ALU_PASS2: r = src2;
            ALU_LINK:  r = src1 + 64'd4;
            default:   r = '0;
        endcase
        if (word_op && alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA})
            r = sext32(r[31:0]);
        case (funct3)
            3'd0:    cond = (cmp1 == cmp2);
            3'd1:    cond = (cmp1 != cmp2);
            3'd4:    cond = $signed(cmp1) < $signed(cmp2);
            3'd5:    cond = $signed(cmp1) >= $signed(cmp2);
            3'd6:    cond = cmp1 < cmp2;
            3'd7:    cond = cmp1 >= cmp2;
            default: cond = 1'b0;
        endcase
        taken = branch ? cond : (jump || jumpr);
        tgt   = jump_base + jump_offset;
        addr  = src1 + src2;
        case (ldst_type)
            LD_HALF, LD_UHALF: mis = addr[0];
            LD_WORD, LD_UWORD: mis = addr[1:0] != 2'b00;
            LD_DOUBLE:         mis = addr[2:0] != 3'b000;
            default:           mis = 1'b0;
        endcase
        return {r, taken, tgt, addr, mis && mem_ctrl_in == MEM_LOAD,
                mis && mem_ctrl_in == MEM_STORE, taken && tgt[1:0] != 2'b00};
    endfunction

    // RISC-V M extension results, word forms on extended low halves
    function automatic logic [63:0] ref_md(input logic [2:0] op, input logic w,
                                           input logic [63:0] a, input logic [63:0] b);
        logic               sa;
        logic               sb;
        logic [63:0]        x;
        logic [63:0]        y;
        logic [127:0]       p;
        logic [63:0]        r;
        logic               ovf;
        logic signed [63:0] sq;
        logic signed [63:0] sr;
        sa  = op inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd6};
        sb  = op inside {3'd0, 3'd1, 3'd4, 3'd6};
        x   = !w ? a : (sa ? sext32(a[31:0]) : {32'd0, a[31:0]});
        y   = !w ? b : (sb ? sext32(b[31:0]) : {32'd0, b[31:0]});
        p   = {{64{sa & x[63]}}, x} * {{64{sb & y[63]}}, y};
        ovf = (x == 64'h8000_0000_0000_0000) && (y == '1);
        sq  = '0;
        sr  = '0;
        if (y != 0 && !ovf)
        begin
            sq = $signed(x) / $signed(y);
            sr = $signed(x) % $signed(y);
        end
        case (op)
            3'd0:    r = p[63:0];
            3'd4:    r = (y == 0) ? '1 : (ovf ? x : sq);
            3'd5:    r = (y == 0) ? '1 : x / y;
            3'd6:    r = (y == 0) ? x : (ovf ? '0 : sr);
            3'd7:    r = (y == 0) ? x : x % y;
            default: r = p[127:64];
        endcase
        return w ? sext32(r[31:0]) : r;
    endfunction

    // Combinational outputs, just before the next edge
    always
    begin
        @(posedge CLK);
        #9;
        if (cmp_en)
        begin
            {e_wb, e_jt, e_ja, e_da, e_lm, e_sm, e_im} = ref_ex();
            if (alu_op != ALU_MULDIV)
                check_val("wb_data", wb_data, e_wb);
            check_val("jump_taken", 64'(jump_taken), 64'(e_jt));
            check_val("jump_addr", jump_addr, e_ja);
            check_val("data_addr", data_addr, e_da);
            check_val("mem_ctrl", 64'(mem_ctrl), 64'(mem_ctrl_in));
            check_val("load_misaligned", 64'(load_misaligned), 64'(e_lm));
            check_val("store_misaligned", 64'(store_misaligned), 64'(e_sm));
            check_val("inst_misaligned", 64'(inst_misaligned), 64'(e_im));
        end
    end

    ////////////////////
    // Test sequences

    task automatic run_muldiv();
        logic [2:0] op;
        logic       w;
        for (int i = 0; i < N_MD; i++)
        begin
            tick();
            w    = (i / 8) % 2;
            op   = 3'(i % 8);
            src1 = rand64();
            src2 = rand64();
            // Word forms exist only for MUL and the divides
            if (w && op inside {3'd1, 3'd2, 3'd3})
                op = 3'd0;
            // Divide by zero, then signed overflow, full width before word
            case (i)
                16, 18, 22: op = 3'd4;
                17:         op = 3'd7;
                19, 21, 23: op = 3'd6;
                20:         op = 3'd5;
                default:    ;
            endcase
            if (i >= 20)
                w = 1'b1;
            if (i inside {16, 17})
                src2 = '0;
            if (i inside {20, 21})
                src2[31:0] = '0;
            if (i inside {18, 19})
                src1 = 64'h8000_0000_0000_0000;
            if (i inside {22, 23})
                src1[31:0] = 32'h8000_0000;
            if (i inside {18, 19, 22, 23})
                src2 = '1;
            alu_op  = ALU_MULDIV;
            funct3  = op;
            word_op = w;
            #7;
            check_true(stalled, "stalled not raised when a muldiv operation is presented");
            while (stalled)
            begin
                tick();
                #7;
            end
            check_val("wb_data", wb_data, ref_md(op, w, src1, src2));
            tick();
            alu_op = ALU_IDLE;
        end
    endtask

    task automatic run_recovery(input int stall_from, input int stall_len,
                                input int exp_flush, input int exp_squash);
        int fc;
        int sc;
        tick();
        alu_op      = ALU_IDLE;
        branch      = 1'b0;
        jump        = 1'b1;
        jump_base   = rand64() & ~64'h3;
        jump_offset = 64'h40;
        pc_id       = jump_base + 64'h44;
        mem_ctrl_in = MEM_LOAD;
        ldst_type   = LD_DOUBLE;
        src1        = 64'h1000;
        src2        = '0;
        #7;
        check_true(!predicted, "predicted high for a mismatched jump target");
        fc = 0;
        sc = 0;
        for (int k = 0; k < 20; k++)
        begin
            tick();
            cache_ready = !(k >= stall_from && k < stall_from + stall_len);
            pc_id       = jump_base + jump_offset;
            #7;
            if (flush)
                fc++;
            if (squash)
            begin
                sc++;
                check_true(!jump_taken && mem_ctrl == MEM_NONE,
                           "jump_taken or mem_ctrl active under squash");
            end
        end
        check_val("flush cycles", 64'(fc), 64'(exp_flush));
        check_val("squash cycles", 64'(sc), 64'(exp_squash));
        check_true(predicted && !flush, "flush raised for a matching jump target");
        tick();
        jump        = 1'b0;
        mem_ctrl_in = MEM_NONE;
        cache_ready = 1'b1;
    endtask

    initial
    begin
        CLK         = 1'b0;
        RST         = 1'b1;
        cache_ready = 1'b1;
        ex_valid    = 1'b0;
        alu_op      = ALU_IDLE;
        word_op     = 1'b0;
        {src1, src2, cmp1, cmp2} = '0;
        {branch, jump, jumpr} = '0;
        funct3      = '0;
        {jump_base, jump_offset, pc_ex, pc_id} = '0;
        mem_ctrl_in = MEM_NONE;
        ldst_type   = LD_BYTE;
        errors      = 0;
        cycles      = 0;
        cmp_en      = 0;
        seed        = 32'h8935_9c3d;
        repeat (4) @(posedge CLK);
        #1;
        RST = 1'b0;
        tick();
        tick();

        cmp_en = 1;
        for (int i = 0; i < N_ALU; i++)
        begin
            tick();
            alu_op  = alu_op_e'(4'(seed % 13));
            word_op = seed[7];
            src1    = rand64();
            src2    = rand64();
        end
        for (int i = 0; i < N_BR; i++)
        begin
            tick();
            alu_op      = ALU_IDLE;
            funct3      = 3'(i % 8);
            branch      = (i < 40);
            jump        = (i >= 40 && i < 44);
            jumpr       = (i >= 44);
            cmp1        = rand64();
            cmp2        = seed[3] ? cmp1 : rand64();
            jump_base   = rand64();
            jump_offset = rand64();
            if (seed[9])
                jump_offset[1:0] = 2'b00;
            pc_id       = jump_base + jump_offset;
        end
        for (int i = 0; i < N_MEM; i++)
        begin
            tick();
            {branch, jump, jumpr} = '0;
            ldst_type   = ldst_type_e'(3'(i % 7));
            mem_ctrl_in = mem_ctrl_e'(2'(seed % 3));
            src1        = rand64();
            src2        = rand64();
        end
        tick();
        cmp_en      = 0;
        mem_ctrl_in = MEM_NONE;

        run_muldiv();
        run_recovery(100, 0, `EX_FLUSH_CYCLES, `EX_SQUASH_CYCLES);
        run_recovery(1, 3, `EX_FLUSH_CYCLES + 3, `EX_SQUASH_CYCLES + 3);

        $display("Run finished with %0d check errors and %0d assertion failures in %0d cycles",
                 errors, ex_stage_i.props_i.fails, cycles);
        if (errors == 0 && ex_stage_i.props_i.fails == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== hdl/ex_alu.sv ====
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_alu
    import ex_pkg::*;
(
    input  alu_op_e              alu_op,
    input  logic                 word_op,
    input  logic [`EX_XLEN-1:0]  src1,
    input  logic [`EX_XLEN-1:0]  src2,
    output logic [`EX_XLEN-1:0]  result
);

    localparam int XLEN = `EX_XLEN;

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] sll_d;
    logic [XLEN-1:0] srl_d;
    logic [XLEN-1:0] sra_d;
    logic [31:0]     sll_w;
    logic [31:0]     srl_w;
    logic [31:0]     sra_w;

    function automatic logic [XLEN-1:0] sext_w(input logic [31:0] v);
        return {{(XLEN-32){v[31]}}, v};
    endfunction

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    // Full width shifts use 6-bit amounts
    assign sll_d = src1 << src2[5:0];
    assign srl_d = src1 >> src2[5:0];
    assign sra_d = $signed(src1) >>> src2[5:0];

    // Word shifts on the low half, 5-bit amounts
    assign sll_w = src1[31:0] << src2[4:0];
    assign srl_w = src1[31:0] >> src2[4:0];
    assign sra_w = $signed(src1[31:0]) >>> src2[4:0];

    always_comb
    begin
        case (alu_op)
            ALU_ADD:   result = word_op ? sext_w(sum[31:0]) : sum;
            ALU_SUB:   result = word_op ? sext_w(diff[31:0]) : diff;
            ALU_SLL:   result = word_op ? sext_w(sll_w) : sll_d;
            ALU_SRL:   result = word_op ? sext_w(srl_w) : srl_d;
            ALU_SRA:   result = word_op ? sext_w(sra_w) : sra_d;
            ALU_XOR:   result = src1 ^ src2;
            ALU_OR:    result = src1 | src2;
            ALU_AND:   result = src1 & src2;
            ALU_SLT:   result = XLEN'($signed(src1) < $signed(src2));
            ALU_SLTU:  result = XLEN'(src1 < src2);
            ALU_PASS1: result = src1;
            ALU_PASS2: result = src2;
            // Return address of a jump
            ALU_LINK:  result = src1 + XLEN'(`EX_LINK_OFFSET);
            // Muldiv result is selected in the stage
            default:   result = '0;
        endcase
    end

endmodule

// ==== hdl/ex_branch_unit.sv ====
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_branch_unit
    import ex_pkg::*;
(
    input  logic                 branch,
    input  logic                 jump,
    input  logic                 jumpr,
    input  branch_op_e           branch_op,
    input  logic [`EX_XLEN-1:0]  cmp1,
    input  logic [`EX_XLEN-1:0]  cmp2,
    input  logic [`EX_XLEN-1:0]  jump_base,
    input  logic [`EX_XLEN-1:0]  jump_offset,
    input  logic                 squash,
    output logic                 jump_taken,
    output logic [`EX_XLEN-1:0]  jump_addr,
    output logic                 inst_misaligned
);

    logic cmp_eq;
    logic cmp_lt;
    logic cmp_ltu;
    logic cond;
    logic taken_raw;

    assign cmp_eq  = (cmp1 == cmp2);
    assign cmp_lt  = ($signed(cmp1) < $signed(cmp2));
    assign cmp_ltu = (cmp1 < cmp2);

    always_comb
    begin
        case (branch_op)
            BEQ:     cond = cmp_eq;
            BNE:     cond = !cmp_eq;
            BLT:     cond = cmp_lt;
            BGE:     cond = !cmp_lt;
            BLTU:    cond = cmp_ltu;
            BGEU:    cond = !cmp_ltu;
            default: cond = 1'b0;
        endcase
    end

    assign taken_raw = branch ? cond : (jump || jumpr);

    // Same adder for branches, jal and jalr
    assign jump_addr = jump_base + jump_offset;

    // Squashed instruction must not redirect or trap
    assign jump_taken      = taken_raw && !squash;
    assign inst_misaligned = taken_raw && (|jump_addr[1:0]) && !squash;

endmodule

// ==== hdl/ex_flush_ctrl.sv ====
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_flush_ctrl
(
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 cache_ready,
    input  logic                 ex_valid,
    input  logic                 jump_taken,
    input  logic [`EX_XLEN-1:0]  jump_addr,
    input  logic [`EX_XLEN-1:0]  pc_ex,
    input  logic [`EX_XLEN-1:0]  pc_id,
    output logic                 flush,
    output logic                 squash,
    output logic                 predicted
);

    localparam int CNT_W = $clog2(`EX_SQUASH_CYCLES + 1);

    logic [1:0]          warm_q;
    logic [CNT_W-1:0]    flush_cnt;
    logic [CNT_W-1:0]    squash_cnt;
    logic [`EX_XLEN-1:0] seq_pc;
    logic                seq_check;
    logic                mispredict;

    assign seq_pc    = pc_ex + `EX_XLEN'(`EX_LINK_OFFSET);
    assign seq_check = ex_valid && !squash && warm_q[1];

    // Taken jump checked against target, else fall-through PC
    always_comb
    begin
        if (jump_taken)
            mispredict = (pc_id != jump_addr);
        else if (seq_check)
            mispredict = (pc_id != seq_pc);
        else
            mispredict = 1'b0;
    end

    assign predicted = !(cache_ready && mispredict);

    ////////////////////
    // Hold timers, frozen while cache not ready

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            warm_q     <= '0;
            flush      <= 1'b0;
            squash     <= 1'b0;
            flush_cnt  <= '0;
            squash_cnt <= '0;
        end
        else if (cache_ready)
        begin
            warm_q <= {warm_q[0], 1'b1};
            if (mispredict)
            begin
                flush      <= 1'b1;
                squash     <= 1'b1;
                flush_cnt  <= CNT_W'(`EX_FLUSH_CYCLES - 1);
                squash_cnt <= CNT_W'(`EX_SQUASH_CYCLES - 1);
            end
            else
            begin
                if (flush && flush_cnt == '0)
                    flush <= 1'b0;
                else if (flush)
                    flush_cnt <= flush_cnt - 1'b1;
                if (squash && squash_cnt == '0)
                    squash <= 1'b0;
                else if (squash)
                    squash_cnt <= squash_cnt - 1'b1;
            end
        end
    end

endmodule

// ==== hdl/ex_mem_addr.sv ====
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_mem_addr
    import ex_pkg::*;
(
    input  mem_ctrl_e            mem_ctrl_in,
    input  ldst_type_e           ldst_type,
    input  logic [`EX_XLEN-1:0]  src1,
    input  logic [`EX_XLEN-1:0]  src2,
    input  logic                 squash,
    output logic [`EX_XLEN-1:0]  data_addr,
    output mem_ctrl_e            mem_ctrl,
    output logic                 load_misaligned,
    output logic                 store_misaligned
);

    logic misaligned;

    assign data_addr = src1 + src2;

    // Natural alignment per access size
    always_comb
    begin
        case (ldst_type)
            LD_HALF, LD_UHALF: misaligned = data_addr[0];
            LD_WORD, LD_UWORD: misaligned = |data_addr[1:0];
            LD_DOUBLE:         misaligned = |data_addr[2:0];
            default:           misaligned = 1'b0;
        endcase
    end

    assign mem_ctrl = squash ? MEM_NONE : mem_ctrl_in;

    assign load_misaligned  = misaligned && (mem_ctrl_in == MEM_LOAD) && !squash;
    assign store_misaligned = misaligned && (mem_ctrl_in == MEM_STORE) && !squash;

endmodule

// ==== hdl/ex_muldiv.sv ====
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_muldiv
    import ex_pkg::*;
(
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 request,
    input  logic                 squash,
    input  muldiv_op_e           op,
    input  logic                 word_op,
    input  logic [`EX_XLEN-1:0]  src1,
    input  logic [`EX_XLEN-1:0]  src2,
    output logic                 done,
    output logic [`EX_XLEN-1:0]  result
);

    localparam int XLEN  = `EX_XLEN;
    localparam int CNT_W = $clog2(XLEN + 1);

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_BUSY,
        MD_DONE
    } md_state_e;

    md_state_e         state;
    logic [CNT_W-1:0]  cnt;
    logic [2*XLEN-1:0] acc;
    logic [XLEN-1:0]   mag_b;
    logic              neg_a;
    logic              neg_b;

    logic              start;
    logic              is_div;
    logic              sign_a;
    logic              sign_b;
    logic [XLEN-1:0]   ext_a;
    logic [XLEN-1:0]   ext_b;
    logic [XLEN:0]     mul_sum;
    logic [XLEN:0]     div_shift;
    logic [XLEN:0]     div_diff;
    logic [2*XLEN-1:0] prod;
    logic [XLEN-1:0]   quo;
    logic [XLEN-1:0]   rem;
    logic [XLEN-1:0]   res_full;

    function automatic logic [XLEN-1:0] sext_w(input logic [31:0] v);
        return {{(XLEN-32){v[31]}}, v};
    endfunction

    assign start  = request && !squash && (state == MD_IDLE);
    assign is_div = op[2];
    assign sign_a = (op == MUL) || (op == MULH) || (op == MULHSU) || (op == DIV) || (op == REM);
    assign sign_b = (op == MUL) || (op == MULH) || (op == DIV) || (op == REM);

    // Word forms see extended low halves
    assign ext_a = !word_op ? src1 : (sign_a ? sext_w(src1[31:0]) : {{(XLEN-32){1'b0}}, src1[31:0]});
    assign ext_b = !word_op ? src2 : (sign_b ? sext_w(src2[31:0]) : {{(XLEN-32){1'b0}}, src2[31:0]});

    ////////////////////
    // One bit per cycle

    assign mul_sum   = {1'b0, acc[2*XLEN-1:XLEN]} + (acc[0] ? {1'b0, mag_b} : '0);
    assign div_shift = {acc[2*XLEN-1:XLEN], acc[XLEN-1]};
    assign div_diff  = div_shift - {1'b0, mag_b};

    // Sign fixup, x/0 gives all ones and keeps the dividend as remainder
    assign prod = (neg_a ^ neg_b) ? -acc : acc;
    assign quo  = (mag_b == '0) ? '1 : ((neg_a ^ neg_b) ? -acc[XLEN-1:0] : acc[XLEN-1:0]);
    assign rem  = neg_a ? -acc[2*XLEN-1:XLEN] : acc[2*XLEN-1:XLEN];

    always_comb
    begin
        case (op)
            MUL:         res_full = prod[XLEN-1:0];
            DIV, DIVU:   res_full = quo;
            REM, REMU:   res_full = rem;
            default:     res_full = prod[2*XLEN-1:XLEN];
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            state <= MD_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                MD_IDLE:
                begin
                    cnt <= '0;
                    if (start)
                        state <= MD_BUSY;
                end
                MD_BUSY:
                begin
                    if (!request || squash)
                        state <= MD_IDLE;
                    else if (cnt == CNT_W'(XLEN))
                        state <= MD_DONE;
                    else
                        cnt <= cnt + 1'b1;
                end
                default:
                begin
                    if (!request)
                        state <= MD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (start)
        begin
            acc   <= {{XLEN{1'b0}}, (sign_a && ext_a[XLEN-1]) ? -ext_a : ext_a};
            mag_b <= (sign_b && ext_b[XLEN-1]) ? -ext_b : ext_b;
            neg_a <= sign_a && ext_a[XLEN-1];
            neg_b <= sign_b && ext_b[XLEN-1];
        end
        else if (state == MD_BUSY && cnt != CNT_W'(XLEN))
        begin
            if (!is_div)
                acc <= {mul_sum, acc[XLEN-1:1]};
            else if (div_diff[XLEN])
                acc <= {div_shift[XLEN-1:0], acc[XLEN-2:0], 1'b0};
            else
                acc <= {div_diff[XLEN-1:0], acc[XLEN-2:0], 1'b1};
        end
        else if (state == MD_BUSY)
        begin
            result <= word_op ? sext_w(res_full[31:0]) : res_full;
        end
    end

    assign done = (state == MD_DONE) && !squash;

endmodule

// ==== hdl/ex_pkg.sv ====
package ex_pkg;

    ////////////////////
    // ALU operation select

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SRL    = 4'd3,
        ALU_SRA    = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_OR     = 4'd6,
        ALU_AND    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_PASS1  = 4'd10,
        ALU_PASS2  = 4'd11,
        ALU_LINK   = 4'd12,
        ALU_MULDIV = 4'd13,
        ALU_IDLE   = 4'd14
    } alu_op_e;

    // Branch funct3, codes 2 and 3 never taken
    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BLT  = 3'd4,
        BGE  = 3'd5,
        BLTU = 3'd6,
        BGEU = 3'd7
    } branch_op_e;

    // M extension funct3
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } muldiv_op_e;

    ////////////////////
    // Memory access

    // Stores use the signed codes only
    typedef enum logic [2:0] {
        LD_BYTE   = 3'd0,
        LD_HALF   = 3'd1,
        LD_WORD   = 3'd2,
        LD_DOUBLE = 3'd3,
        LD_UBYTE  = 3'd4,
        LD_UHALF  = 3'd5,
        LD_UWORD  = 3'd6
    } ldst_type_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_ctrl_e;

endpackage

// ==== hdl/ex_stage.sv ====
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_stage
    import ex_pkg::*;
(
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 cache_ready,
    input  logic                 ex_valid,
    input  alu_op_e              alu_op,
    input  logic                 word_op,
    input  logic [`EX_XLEN-1:0]  src1,
    input  logic [`EX_XLEN-1:0]  src2,
    input  logic [`EX_XLEN-1:0]  cmp1,
    input  logic [`EX_XLEN-1:0]  cmp2,
    input  logic                 branch,
    input  logic                 jump,
    input  logic                 jumpr,
    input  logic [2:0]           funct3,
    input  logic [`EX_XLEN-1:0]  jump_base,
    input  logic [`EX_XLEN-1:0]  jump_offset,
    input  logic [`EX_XLEN-1:0]  pc_ex,
    input  logic [`EX_XLEN-1:0]  pc_id,
    input  mem_ctrl_e            mem_ctrl_in,
    input  ldst_type_e           ldst_type,
    output logic [`EX_XLEN-1:0]  wb_data,
    output logic                 jump_taken,
    output logic [`EX_XLEN-1:0]  jump_addr,
    output logic [`EX_XLEN-1:0]  data_addr,
    output mem_ctrl_e            mem_ctrl,
    output logic                 load_misaligned,
    output logic                 store_misaligned,
    output logic                 inst_misaligned,
    output logic                 stalled,
    output logic                 flush,
    output logic                 squash,
    output logic                 predicted
);

    logic [`EX_XLEN-1:0] alu_result;
    logic [`EX_XLEN-1:0] md_result;
    logic                md_request;
    logic                md_done;
    branch_op_e          branch_op;
    muldiv_op_e          md_op;

    assign branch_op  = branch_op_e'(funct3);
    assign md_op      = muldiv_op_e'(funct3);
    assign md_request = (alu_op == ALU_MULDIV);

    assign wb_data = md_request ? md_result : alu_result;

    // Hold the stage until the muldiv result is in
    assign stalled = md_request && !md_done && !squash;

    ex_alu alu_i (
        .alu_op  (alu_op),
        .word_op (word_op),
        .src1    (src1),
        .src2    (src2),
        .result  (alu_result)
    );

    ex_branch_unit branch_i (
        .branch          (branch),
        .jump            (jump),
        .jumpr           (jumpr),
        .branch_op       (branch_op),
        .cmp1            (cmp1),
        .cmp2            (cmp2),
        .jump_base       (jump_base),
        .jump_offset     (jump_offset),
        .squash          (squash),
        .jump_taken      (jump_taken),
        .jump_addr       (jump_addr),
        .inst_misaligned (inst_misaligned)
    );

    ex_muldiv muldiv_i (
        .CLK     (CLK),
        .RST     (RST),
        .request (md_request),
        .squash  (squash),
        .op      (md_op),
        .word_op (word_op),
        .src1    (src1),
        .src2    (src2),
        .done    (md_done),
        .result  (md_result)
    );

    ex_mem_addr mem_addr_i (
        .mem_ctrl_in      (mem_ctrl_in),
        .ldst_type        (ldst_type),
        .src1             (src1),
        .src2             (src2),
        .squash           (squash),
        .data_addr        (data_addr),
        .mem_ctrl         (mem_ctrl),
        .load_misaligned  (load_misaligned),
        .store_misaligned (store_misaligned)
    );

    ex_flush_ctrl flush_ctrl_i (
        .CLK         (CLK),
        .RST         (RST),
        .cache_ready (cache_ready),
        .ex_valid    (ex_valid),
        .jump_taken  (jump_taken),
        .jump_addr   (jump_addr),
        .pc_ex       (pc_ex),
        .pc_id       (pc_id),
        .flush       (flush),
        .squash      (squash),
        .predicted   (predicted)
    );

endmodule

// ==== include/ex_settings.svh ====
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

////////////////////
// Data path

`define EX_XLEN 64

// Instruction size, for link value and sequential PC
`define EX_LINK_OFFSET 4

////////////////////
// Misprediction recovery

// Front-end flush length in ready cycles
`define EX_FLUSH_CYCLES 4
// Internal squash, kept longer than the flush
`define EX_SQUASH_CYCLES 6

`endif

// ==== project.f ====
+incdir+include
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_branch_unit.sv
hdl/ex_muldiv.sv
hdl/ex_mem_addr.sv
hdl/ex_flush_ctrl.sv
hdl/ex_stage.sv
bench/ex_stage_properties.sv
bench/ex_stage_tb.sv
